// ==== runSim.sh ====
#!/bin/sh
# Build the load cluster testbench with Verilator and run it.
# The simulator's exit status carries pass or fail.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module ldstClusterTb \
	-f src.f \
	-o simLdstCluster

./obj_dir/simLdstCluster

// ==== sim/ldstClusterTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Strided load cluster testbench
// Token table, memory model with hashed data, scoreboard of words,
// reads and commits, random consumer stalls and a watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module ldstClusterTb
	import ldstPkg::*;
;

	localparam int NumLanes		= `LDST_NUM_LANES;
	localparam int NumRows		= 12;
	localparam int ResetCycles	= 10;

	typedef struct packed {
		logic		expectStall;		// Lane queue full when presented
		laneIdT		lane;
		issueNoT	issueNo;
		accessT		access;
	} rowT;

	logic						clock = 1'b0;
	logic						reset;
	loadTokenT					issueToken;
	logic						issueStall;
	logic						memRead;
	addressT					memAddr;
	dataT						memData = '0;
	logic [NumLanes-1:0]		dataStall = '0;
	dataT [NumLanes-1:0]		loadData;
	logic [NumLanes-1:0]		loadValid;
	commitT						commit;

	rowT		rows [NumRows];
	int			baseToRow [addressT];
	int			issueRow [issueNoT];
	dataT		expWords [NumLanes][$];		// Per-lane scoreboard
	issueNoT	expIssue [NumLanes][$];
	bit			started [NumRows];
	bit			readsDone [NumRows];
	bit			committed [NumRows];
	bit			tableReady = 1'b0;
	int			curRow = 0;
	int			curIdx = 0;
	int			curLeft = 0;		// Reads left in the access being walked
	int			readCount = 0;
	int			commitCount = 0;
	logic		readLatched = 1'b0;
	addressT	addrLatched = '0;
	logic [NumLanes-1:0]	prevHeld = '0;
	dataT [NumLanes-1:0]	prevData;
	logic [31:0]			rngState = 32'd36;

	ldstCluster ldstCluster_inst (
		.clock, .reset, .issueToken, .issueStall, .memRead, .memAddr, .memData,
		.dataStall, .loadData, .loadValid, .commit
	);

	always #4 clock = ~clock;

	function automatic dataT hashWord(input addressT addr);
		return ({addr, addr ^ 16'hC35A} * 32'h9E37_79B1) ^ 32'h0F1E_2D3C;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic rowT makeRow(input int lane, input int issueNo, input addressT base,
			input addressT stride, input int length, input logic expectStall);
		rowT row;
		row.expectStall	= expectStall;
		row.lane		= laneIdT'(lane);
		row.issueNo		= issueNoT'(issueNo);
		row.access		= '{base: base, stride: stride, length: addressT'(length)};
		return row;
	endfunction

	function automatic int totalLength();
		int sum;
		sum = 0;
		for (int r = 0; r < NumRows; r++) sum += int'(rows[r].access.length);
		return sum;
	endfunction

	function automatic bit queuesEmpty();
		bit empty;
		empty = 1'b1;
		for (int lane = 0; lane < NumLanes; lane++) empty &= (expWords[lane].size() == 0);
		return empty;
	endfunction

	task automatic abortRun(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Token table with distinct bases so each read run maps back to its row
	task automatic loadTable();
		rows[0]		= makeRow(2, 1, 16'h0100, 16'h0004, 8, 1'b0);		// Fills lane 2
		rows[1]		= makeRow(2, 2, 16'h0200, 16'h0001, 8, 1'b0);
		rows[2]		= makeRow(2, 3, 16'h0300, 16'h0002, 8, 1'b0);
		rows[3]		= makeRow(2, 4, 16'h0400, 16'h0008, 8, 1'b0);
		rows[4]		= makeRow(2, 5, 16'h0500, 16'h0003, 6, 1'b1);		// Fifth token stalls
		rows[5]		= makeRow(0, 6, 16'h1000, 16'h0010, 20, 1'b0);		// Longer than the ring
		rows[6]		= makeRow(1, 7, 16'h2000, 16'h0000, 5, 1'b0);
		rows[7]		= makeRow(3, 8, 16'h3000, 16'hFFFE, 12, 1'b0);		// Walks downward
		rows[8]		= makeRow(0, 9, 16'h4000, 16'h0005, 3, 1'b0);
		rows[9]		= makeRow(1, 10, 16'h5000, 16'h0007, 1, 1'b0);
		rows[10]	= makeRow(3, 11, 16'h6000, 16'h0001, 17, 1'b0);
		rows[11]	= makeRow(2, 12, 16'h7000, 16'h0020, 4, 1'b0);
		for (int r = 0; r < NumRows; r++) begin
			baseToRow[rows[r].access.base]	= r;
			issueRow[rows[r].issueNo]		= r;
		end
	endtask

	task automatic applyRow(input int r);
		int stallCycles;
		stallCycles = 0;
		@(posedge clock);
		#1;
		issueToken = '{valid: 1'b1, issueNo: rows[r].issueNo, laneId: rows[r].lane,
			access: rows[r].access};
		@(negedge clock);
		while (issueStall) begin
			stallCycles++;
			@(negedge clock);
		end
		assert (!rows[r].expectStall || stallCycles > 1) else
			abortRun($sformatf("Token %0d to a full lane queue was not held off", r));
		for (int i = 0; i < int'(rows[r].access.length); i++) begin
			expWords[rows[r].lane].push_back(hashWord(rows[r].access.base +
				addressT'(i) * rows[r].access.stride));
		end
		expIssue[rows[r].lane].push_back(rows[r].issueNo);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitors on the falling edge
	task automatic traceRead();
		addressT expected;
		if (curLeft == 0) begin
			assert (baseToRow.exists(memAddr) && !started[baseToRow[memAddr]]) else
				abortRun($sformatf("Read of address %h starts no pending load", memAddr));
			curRow			= baseToRow[memAddr];
			started[curRow]	= 1'b1;
			curIdx			= 0;
			curLeft			= int'(rows[curRow].access.length);
		end
		expected = rows[curRow].access.base + addressT'(curIdx) * rows[curRow].access.stride;
		assert (memAddr == expected) else
			abortRun($sformatf("ERROR memAddr got %h expected %h", memAddr, expected));
		curIdx++;
		curLeft--;
		readCount++;
		if (curLeft == 0) readsDone[curRow] = 1'b1;
	endtask

	task automatic compareLaneData();
		for (int lane = 0; lane < NumLanes; lane++) begin
			if (prevHeld[lane]) begin
				assert (loadValid[lane] && loadData[lane] == prevData[lane]) else
					abortRun($sformatf("Lane %0d lost or changed its word under stall", lane));
			end
			if (loadValid[lane]) begin
				assert (expWords[lane].size() > 0) else
					abortRun($sformatf("Lane %0d delivered an extra word", lane));
				assert (loadData[lane] == expWords[lane][0]) else
					abortRun($sformatf("ERROR loadData[%0d] got %h expected %h", lane,
						loadData[lane], expWords[lane][0]));
				if (!dataStall[lane]) void'(expWords[lane].pop_front());
			end
			prevHeld[lane] = loadValid[lane] & dataStall[lane];
			prevData[lane] = loadData[lane];
		end
	endtask

	task automatic matchCommit();
		int row;
		int lane;
		assert (issueRow.exists(commit.issueNo)) else
			abortRun($sformatf("Commit of issue number %h that was never issued",
				commit.issueNo));
		row		= issueRow[commit.issueNo];
		lane	= int'(rows[row].lane);
		assert (!committed[row]) else
			abortRun($sformatf("Issue number %h committed twice", commit.issueNo));
		assert (readsDone[row]) else
			abortRun($sformatf("Issue number %h committed before its last read",
				commit.issueNo));
		assert (expIssue[lane].size() > 0) else
			abortRun($sformatf("Lane %0d committed more loads than it was given", lane));
		assert (commit.issueNo == expIssue[lane][0]) else
			abortRun($sformatf("ERROR commit.issueNo got %h expected %h", commit.issueNo,
				expIssue[lane][0]));
		void'(expIssue[lane].pop_front());
		committed[row] = 1'b1;
		commitCount++;
	endtask

	always @(negedge clock) begin
		readLatched	= memRead & ~reset;
		addrLatched	= memAddr;
		if (!reset) begin
			if (memRead) traceRead();
			compareLaneData();
			if (commit.valid) matchCommit();
		end
	end

	// Memory answers one cycle after the read
	always @(posedge clock) begin
		#1;
		memData		= readLatched ? hashWord(addrLatched) : '0;
		rngState	= xorshift(rngState);
		for (int lane = 0; lane < NumLanes; lane++) begin
			if (lane == 0) begin
				dataStall[lane] = (rngState[31:28] != 4'h0);		// Slow consumer so the ring fills
			end else begin
				dataStall[lane] = (rngState[2*lane +: 2] == 2'b00);		// About a quarter of cycles
			end
		end
	end

	initial begin
		int limit;
		wait (tableReady);
		limit = totalLength() * 40 + ResetCycles;
		repeat (limit) @(posedge clock);
		$display("Watchdog expired after %0d cycles with loads still outstanding", limit);
		$display("Test failures found");
		$fatal(1);
	end

	initial begin
		reset		= 1'b1;
		issueToken	= '0;
		loadTable();
		tableReady	= 1'b1;
		repeat (ResetCycles) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		assert (!issueStall && !memRead && loadValid == '0 && !commit.valid) else
			abortRun("Outputs were not idle after reset");
		for (int r = 0; r < NumRows; r++) applyRow(r);
		@(posedge clock);
		#1;
		issueToken = '0;
		while (commitCount < NumRows || !queuesEmpty()) @(negedge clock);
		repeat (4) @(negedge clock);
		assert (readCount == totalLength()) else
			abortRun($sformatf("ERROR memRead count got %h expected %h", readCount,
				totalLength()));
		assert (loadValid == '0 && !commit.valid) else
			abortRun("Outputs still active after all loads completed");
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+src
src/ldstPkg.sv
src/issueDispatch.sv
src/tokenQueue.sv
src/dataRing.sv
src/ldstUnit.sv
src/memorySequencer.sv
src/commitArbiter.sv
src/ldstCluster.sv
sim/ldstClusterTb.sv

// ==== src/commitArbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Commit arbiter
// Holds lane commit requests and drains one per cycle, round robin
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module commitArbiter
	import ldstPkg::*;
(
	input	logic							clock,
	input	logic							reset,
	input	logic [`LDST_NUM_LANES-1:0]		commitReq,
	input	issueNoT [`LDST_NUM_LANES-1:0]	commitNo,
	output	commitT							commit
);

	logic [`LDST_NUM_LANES-1:0]		pending;
	issueNoT						latchedNo [`LDST_NUM_LANES];
	laneIdT							lastWinner;
	laneIdT							winner;
	logic							found;
	logic [`LDST_NUM_LANES-1:0]		winMask;
	logic							commitValid;
	issueNoT						commitIssue;

	always_comb begin
		int idx;
		found	= 1'b0;
		winner	= lastWinner;
		for (int k = 1; k <= `LDST_NUM_LANES; k++) begin
			idx = (int'(lastWinner) + k) % `LDST_NUM_LANES;
			if (!found && pending[idx]) begin
				found	= 1'b1;
				winner	= laneIdT'(idx);
			end
		end
		winMask = found ? (`LDST_NUM_LANES)'(1) << winner : '0;
	end

	assign commit = '{valid: commitValid, issueNo: commitIssue};

	always_ff @(posedge clock) begin
		if (reset) begin
			pending		<= '0;
			lastWinner	<= laneIdT'(`LDST_NUM_LANES - 1);
			commitValid	<= 1'b0;
		end else begin
			pending		<= (pending & ~winMask) | commitReq;		// New request wins
			commitValid	<= found;
			if (found) lastWinner <= winner;
		end
	end

	always_ff @(posedge clock) begin
		commitIssue <= latchedNo[winner];
		for (int lane = 0; lane < `LDST_NUM_LANES; lane++) begin
			if (commitReq[lane]) latchedNo[lane] <= commitNo[lane];
		end
	end

endmodule

// ==== src/dataRing.sv ====
////////////////////////////////////////////////////////////////////////////
// Data ring
// Power-of-two ring buffer of returned words with occupancy count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module dataRing
	import ldstPkg::*;
#(
	parameter int Depth			= `LDST_RING_DEPTH,
	parameter int IndexWidth	= $clog2(Depth)
)(
	input	logic					clock,
	input	logic					reset,
	input	logic					write,
	input	dataT					writeData,
	input	logic					read,
	output	dataT					readData,
	output	logic					full,
	output	logic					empty,
	output	logic [IndexWidth:0]	count
);

	dataT						words [Depth];
	logic [IndexWidth-1:0]		writePtr;
	logic [IndexWidth-1:0]		readPtr;
	logic						doWrite;
	logic						doRead;

	assign doWrite	= write & ~full;
	assign doRead	= read & ~empty;
	assign full		= (count == (IndexWidth+1)'(Depth));
	assign empty	= (count == '0);
	assign readData	= words[readPtr];		// Head word, no read latency

	always_ff @(posedge clock) begin
		if (doWrite) begin
			words[writePtr] <= writeData;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr	<= '0;
			readPtr		<= '0;
			count		<= '0;
		end else begin
			if (doWrite) writePtr <= writePtr + 1'b1;
			if (doRead) readPtr <= readPtr + 1'b1;
			count <= count + (IndexWidth+1)'(doWrite) - (IndexWidth+1)'(doRead);
		end
	end

endmodule

// ==== src/issueDispatch.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue dispatch
// Registers an issued load token and routes it to its lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module issueDispatch
	import ldstPkg::*;
(
	input	logic							clock,
	input	logic							reset,
	input	loadTokenT						issueToken,
	output	logic							issueStall,
	input	logic [`LDST_NUM_LANES-1:0]		queueFull,
	output	loadTokenT [`LDST_NUM_LANES-1:0]	laneToken
);

	logic			heldValid;
	loadTokenT		heldToken;		// Routing register payload
	logic			targetBusy;
	logic			accept;

	// The held token is not yet in its queue, so a second token to the
	// same lane waits one cycle until the queue's full flag catches up
	assign targetBusy	= queueFull[issueToken.laneId] |
						  (heldValid & (heldToken.laneId == issueToken.laneId));
	assign issueStall	= issueToken.valid & targetBusy;
	assign accept		= issueToken.valid & ~targetBusy;

	always_ff @(posedge clock) begin
		if (reset) begin
			heldValid <= 1'b0;
		end else begin
			heldValid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			heldToken <= issueToken;
		end
	end

	always_comb begin
		for (int lane = 0; lane < `LDST_NUM_LANES; lane++) begin
			laneToken[lane]			= heldToken;
			laneToken[lane].valid	= heldValid & (heldToken.laneId == laneIdT'(lane));
		end
	end

endmodule

// ==== src/ldstCluster.sv ====
////////////////////////////////////////////////////////////////////////////
// Strided load cluster
// Dispatch, load lanes, shared memory sequencer and commit arbiter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module ldstCluster
	import ldstPkg::*;
(
	input	logic							clock,
	input	logic							reset,
	input	loadTokenT						issueToken,
	output	logic							issueStall,
	output	logic							memRead,
	output	addressT						memAddr,
	input	dataT							memData,
	input	logic [`LDST_NUM_LANES-1:0]		dataStall,
	output	dataT [`LDST_NUM_LANES-1:0]		loadData,
	output	logic [`LDST_NUM_LANES-1:0]		loadValid,
	output	commitT							commit
);

	loadTokenT [`LDST_NUM_LANES-1:0]	laneToken;
	logic [`LDST_NUM_LANES-1:0]			queueFull;
	logic [`LDST_NUM_LANES-1:0]			laneReq;
	accessT [`LDST_NUM_LANES-1:0]		laneAccess;
	logic [`LDST_NUM_LANES-1:0]			laneRoom;
	logic [`LDST_NUM_LANES-1:0]			laneGrant;
	memReturnT [`LDST_NUM_LANES-1:0]	laneReturn;
	logic [`LDST_NUM_LANES-1:0]			laneCommit;
	issueNoT [`LDST_NUM_LANES-1:0]		laneCommitNo;

	issueDispatch issueDispatch_inst (
		.clock, .reset, .issueToken, .issueStall, .queueFull, .laneToken
	);

	for (genvar lane = 0; lane < `LDST_NUM_LANES; lane++) begin : genLane
		ldstUnit ldstUnit_inst (
			.clock		(clock),
			.reset		(reset),
			.token		(laneToken[lane]),
			.grant		(laneGrant[lane]),
			.memReturn	(laneReturn[lane]),
			.dataStall	(dataStall[lane]),
			.request	(laneReq[lane]),
			.access		(laneAccess[lane]),
			.room		(laneRoom[lane]),
			.queueFull	(queueFull[lane]),
			.loadData	(loadData[lane]),
			.loadValid	(loadValid[lane]),
			.commitReq	(laneCommit[lane]),
			.commitNo	(laneCommitNo[lane])
		);
	end

	memorySequencer memorySequencer_inst (
		.clock, .reset, .laneReq, .laneAccess, .laneRoom, .laneGrant, .laneReturn,
		.memRead, .memAddr, .memData
	);

	commitArbiter commitArbiter_inst (
		.clock, .reset, .commitReq(laneCommit), .commitNo(laneCommitNo), .commit
	);

endmodule

// ==== src/ldstPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Load cluster types
// Token, strided access, memory return and commit records
////////////////////////////////////////////////////////////////////////////

`include "ldst_params.svh"

package ldstPkg;

	typedef logic [`LDST_DATA_WIDTH-1:0]	dataT;
	typedef logic [`LDST_ADDR_WIDTH-1:0]	addressT;
	typedef logic [`LDST_ISSUE_WIDTH-1:0]	issueNoT;
	typedef logic [`LDST_LANE_WIDTH-1:0]	laneIdT;

	typedef struct packed {
		addressT	base;
		addressT	stride;
		addressT	length;		// Words, never zero
	} accessT;

	typedef struct packed {
		logic		valid;
		issueNoT	issueNo;
		laneIdT		laneId;
		accessT		access;
	} loadTokenT;

	typedef struct packed {
		logic		valid;
		logic		term;		// Last word of the access
		dataT		data;
	} memReturnT;

	typedef struct packed {
		logic		valid;
		issueNoT	issueNo;
	} commitT;

	typedef enum logic [1:0] {seqIdle, seqGrant, seqStream, seqDrain} seqStateT;

endpackage

// ==== src/ldstUnit.sv ====
////////////////////////////////////////////////////////////////////////////
// Load lane
// Token queue plus data ring; streams words out and requests commits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module ldstUnit
	import ldstPkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	loadTokenT	token,
	input	logic		grant,
	input	memReturnT	memReturn,
	input	logic		dataStall,
	output	logic		request,
	output	accessT		access,
	output	logic		room,
	output	logic		queueFull,
	output	dataT		loadData,
	output	logic		loadValid,
	output	logic		commitReq,
	output	issueNoT	commitNo
);

	localparam int RingIdxWidth = $clog2(`LDST_RING_DEPTH);
	localparam logic [RingIdxWidth:0] RoomLimit = `LDST_RING_DEPTH - 2;

	logic						running;
	logic						term;
	issueNoT					headNo;
	logic						ringRead;
	logic						ringFull;
	logic						ringEmpty;
	logic [RingIdxWidth:0]		ringCount;

	assign term			= memReturn.valid & memReturn.term & running;
	assign ringRead		= ~ringEmpty & ~dataStall;
	assign loadValid	= ~ringEmpty;
	assign room			= ~ringFull & (ringCount <= RoomLimit);		// Two free slots

	tokenQueue tokenQueue_inst (
		.clock		(clock),
		.reset		(reset),
		.pushToken	(token),
		.grant		(grant),
		.term		(term),
		.request	(request),
		.access		(access),
		.commitNo	(headNo),
		.full		(queueFull),
		.running	(running)
	);

	dataRing dataRing_inst (
		.clock		(clock),
		.reset		(reset),
		.write		(memReturn.valid),
		.writeData	(memReturn.data),
		.read		(ringRead),
		.readData	(loadData),
		.full		(ringFull),
		.empty		(ringEmpty),
		.count		(ringCount)
	);

	// Commit one cycle after the last word, head number taken before pop
	always_ff @(posedge clock) begin
		if (reset) begin
			commitReq <= 1'b0;
		end else begin
			commitReq <= term;
		end
	end

	always_ff @(posedge clock) begin
		if (term) begin
			commitNo <= headNo;
		end
	end

endmodule

// ==== src/ldst_params.svh ====
////////////////////////////////////////////////////////////////////////////
// Load cluster parameters
// Lane count, queue and ring depths, field widths
////////////////////////////////////////////////////////////////////////////

`ifndef LDST_PARAMS_SVH
`define LDST_PARAMS_SVH

`define LDST_NUM_LANES		4		// Load lanes in the cluster
`define LDST_QUEUE_DEPTH	4		// Pending tokens per lane
`define LDST_RING_DEPTH		16		// Data words per lane, power of two

`define LDST_DATA_WIDTH		32
`define LDST_ADDR_WIDTH		16		// Address, stride and length
`define LDST_ISSUE_WIDTH	6
`define LDST_LANE_WIDTH		2

`endif

// ==== src/memorySequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory sequencer
// Round-robin grant of the memory port and strided address walk
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module memorySequencer
	import ldstPkg::*;
(
	input	logic								clock,
	input	logic								reset,
	input	logic [`LDST_NUM_LANES-1:0]			laneReq,
	input	accessT [`LDST_NUM_LANES-1:0]		laneAccess,
	input	logic [`LDST_NUM_LANES-1:0]			laneRoom,
	output	logic [`LDST_NUM_LANES-1:0]			laneGrant,
	output	memReturnT [`LDST_NUM_LANES-1:0]	laneReturn,
	output	logic								memRead,
	output	addressT							memAddr,
	input	dataT								memData
);

	seqStateT	state;
	laneIdT		curLane;		// Lane being served, or last served
	laneIdT		nextLane;
	logic		anyReq;
	addressT	addr;
	addressT	stride;
	addressT	remaining;		// Reads still to issue
	logic		lastRead;
	logic		returnValid;
	logic		returnTerm;

	////////////////////////////////////////////////////////////////////////////
	// Round-robin pick, starting after the last lane served
	always_comb begin
		int idx;
		anyReq		= 1'b0;
		nextLane	= curLane;
		for (int k = 1; k <= `LDST_NUM_LANES; k++) begin
			idx = (int'(curLane) + k) % `LDST_NUM_LANES;
			if (!anyReq && laneReq[idx]) begin
				anyReq		= 1'b1;
				nextLane	= laneIdT'(idx);
			end
		end
	end

	assign memRead	= (state == seqStream) & laneRoom[curLane];		// Ring back-pressure
	assign memAddr	= addr;
	assign lastRead	= (remaining == addressT'(1));

	always_comb begin
		for (int lane = 0; lane < `LDST_NUM_LANES; lane++) begin
			laneGrant[lane]			= (state == seqGrant) & (curLane == laneIdT'(lane));
			laneReturn[lane].valid	= returnValid & (curLane == laneIdT'(lane));
			laneReturn[lane].term	= returnTerm;
			laneReturn[lane].data	= memData;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= seqIdle;
			curLane		<= laneIdT'(`LDST_NUM_LANES - 1);		// Lane 0 wins first
			returnValid	<= 1'b0;
		end else begin
			returnValid <= memRead;		// One cycle memory latency
			case (state)
				seqIdle: if (anyReq) begin
					curLane	<= nextLane;
					state	<= seqGrant;
				end
				seqGrant: state <= seqStream;
				seqStream: if (memRead && lastRead) state <= seqDrain;
				seqDrain: if (returnValid && returnTerm) begin
					curLane	<= anyReq ? nextLane : curLane;
					state	<= anyReq ? seqGrant : seqIdle;
				end
				default: state <= seqIdle;
			endcase
		end
	end

	// Descriptor latch and address walk
	always_ff @(posedge clock) begin
		returnTerm <= memRead & lastRead;
		if (state == seqGrant) begin
			addr		<= laneAccess[curLane].base;
			stride		<= laneAccess[curLane].stride;
			remaining	<= laneAccess[curLane].length;
		end else if (memRead) begin
			addr		<= addr + stride;
			remaining	<= remaining - addressT'(1);
		end
	end

endmodule

// ==== src/tokenQueue.sv ====
////////////////////////////////////////////////////////////////////////////
// Token queue
// Per-lane FIFO of pending loads; head token drives the access request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ldst_params.svh"

module tokenQueue
	import ldstPkg::*;
#(
	parameter int Depth			= `LDST_QUEUE_DEPTH,
	parameter int IndexWidth	= $clog2(Depth)
)(
	input	logic		clock,
	input	logic		reset,
	input	loadTokenT	pushToken,
	input	logic		grant,
	input	logic		term,
	output	logic		request,
	output	accessT		access,
	output	issueNoT	commitNo,
	output	logic		full,
	output	logic		running
);

	loadTokenT					entries [Depth];
	logic [IndexWidth-1:0]		writePtr;
	logic [IndexWidth-1:0]		readPtr;
	logic [IndexWidth:0]		count;
	logic						empty;
	logic						push;
	logic						pop;

	assign push		= pushToken.valid & ~full;
	assign pop		= term & ~empty;
	assign empty	= (count == '0);
	assign full		= (count == (IndexWidth+1)'(Depth));

	assign request	= ~empty & ~running;		// Head not started yet
	assign access	= entries[readPtr].access;
	assign commitNo	= entries[readPtr].issueNo;

	always_ff @(posedge clock) begin
		if (push) begin
			entries[writePtr] <= pushToken;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr	<= '0;
			readPtr		<= '0;
			count		<= '0;
			running		<= 1'b0;
		end else begin
			if (push) writePtr <= writePtr + 1'b1;
			if (pop) readPtr <= readPtr + 1'b1;
			count <= count + (IndexWidth+1)'(push) - (IndexWidth+1)'(pop);
			if (term) begin
				running <= 1'b0;		// Access done, head retires
			end else if (grant & ~empty) begin
				running <= 1'b1;
			end
		end
	end

endmodule
